/* bench/sample_buffer_checker.sv */
module sample_buffer_checker (
  input logic                        ps_clk,
  input logic                        arst_n_i,
  input buffer_pkg::capture_cmd_t    cmd_i,
  input buffer_pkg::capture_state_e  state_i,
  input buffer_pkg::readout_word_t   readout_i,
  input buffer_pkg::depth_t          depth_i,
  input logic                        capture_busy_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // a frame marker never stands alone
  last_needs_valid: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    readout_i.last |-> readout_i.valid)
    else $error("readout last seen without valid");

  // readout is locked out while a capture is armed or running
  quiet_while_busy: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    capture_busy_i |-> !readout_i.valid)
    else $error("readout word seen while capture busy");

  idle_needs_cmd: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    ((state_i == buffer_pkg::IDLE) && !cmd_i.valid) |=> (state_i == buffer_pkg::IDLE))
    else $error("capture state left IDLE without a command");

  depth_in_range: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    (depth_i.samples <= buffer_pkg::SAMPLE_DEPTH) &&
    (depth_i.tstamps <= buffer_pkg::TSTAMP_DEPTH))
    else $error("depth count beyond memory size");

endmodule

bind timetagging_sample_buffer sample_buffer_checker u_checker (
  .ps_clk         (ps_clk),
  .arst_n_i       (arst_n_i),
  .cmd_i          (cmd_i),
  .state_i        (u_capture_control.state),
  .readout_i      (readout_o),
  .depth_i        (depth_o),
  .capture_busy_i (capture_busy_o)
);

/* bench/tb_timetagging_sample_buffer.sv */
module tb_timetagging_sample_buffer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 50;

  logic                       ps_clk;
  logic                       arst_n;
  rx_pkg::sample_in_t         sample;
  rx_pkg::tstamp_in_t         tstamp;
  logic                       trigger;
  buffer_pkg::capture_cmd_t   cmd;
  logic                       readout_start;
  buffer_pkg::readout_word_t  readout;
  buffer_pkg::depth_t         depth;
  logic                       capture_busy;

  // reference model of the capture
  buffer_pkg::capture_state_e      m_state;
  logic [buffer_pkg::OUT_WIDTH-1:0] s_q[$];
  logic [buffer_pkg::OUT_WIDTH-1:0] t_q[$];

  int    seed = 35297;
  int    errors;
  int    checks;
  int    tests;
  int    test_err_start;
  string cur_test;

  timetagging_sample_buffer u_dut (
    .ps_clk          (ps_clk),
    .arst_n_i        (arst_n),
    .sample_i        (sample),
    .tstamp_i        (tstamp),
    .trigger_i       (trigger),
    .cmd_i           (cmd),
    .readout_start_i (readout_start),
    .readout_o       (readout),
    .depth_o         (depth),
    .capture_busy_o  (capture_busy)
  );

  always #20 ps_clk = ~ps_clk;

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic compare_word(input string name, input buffer_pkg::readout_word_t exp,
                              input buffer_pkg::readout_word_t act);
    checks++;
    if (act.valid !== exp.valid || act.data !== exp.data) begin
      $display("FAIL %s: word expected %b/%h actual %b/%h", name,
               exp.valid, exp.data, act.valid, act.data);
      errors++;
    end
  endtask

  task automatic expect_last(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s: last expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_depth(input string name, input buffer_pkg::depth_t exp,
                               input buffer_pkg::depth_t act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s: depth expected %0d/%0d actual %0d/%0d", name,
               exp.samples, exp.tstamps, act.samples, act.tstamps);
      errors++;
    end
  endtask

  // one clock of stimulus, entered and left on a falling edge
  task automatic step(input logic cmd_v, input buffer_pkg::cmd_op_e op, input logic trig,
                      input logic s_v, input logic t_v);
    logic clr;
    logic full;
    int   r;
    cmd.valid = cmd_v;
    cmd.op    = op;
    trigger   = trig;
    r = $random(seed);
    sample.valid = s_v;
    sample.lanes = r;
    r = $random(seed);
    tstamp.valid = t_v;
    tstamp.value = r;
    @(posedge ps_clk);
    // a new arm or a reset empties the memories
    clr = cmd_v && ((op == buffer_pkg::CMD_RESET) || ((op != buffer_pkg::CMD_STOP) &&
          (m_state == buffer_pkg::IDLE || m_state == buffer_pkg::DONE)));
    full = (s_q.size() == buffer_pkg::SAMPLE_DEPTH) || (t_q.size() == buffer_pkg::TSTAMP_DEPTH);
    if (m_state == buffer_pkg::CAPTURING && !full && !clr) begin
      if (s_v) s_q.push_back({sample.lanes[1], sample.lanes[0]});
      if (t_v) t_q.push_back(tstamp.value);
    end
    if (clr) begin
      s_q.delete();
      t_q.delete();
    end
    if (cmd_v && op == buffer_pkg::CMD_RESET) begin
      m_state = buffer_pkg::IDLE;
    end else begin
      case (m_state)
        buffer_pkg::IDLE, buffer_pkg::DONE: begin
          if (cmd_v && op == buffer_pkg::CMD_ARM_START) m_state = buffer_pkg::CAPTURING;
          else if (cmd_v && op == buffer_pkg::CMD_ARM) m_state = buffer_pkg::ARMED;
        end
        buffer_pkg::ARMED: begin
          if (cmd_v && op == buffer_pkg::CMD_STOP) m_state = buffer_pkg::DONE;
          else if (trig) m_state = buffer_pkg::CAPTURING;
        end
        default: begin
          if ((cmd_v && op == buffer_pkg::CMD_STOP) || full) m_state = buffer_pkg::DONE;
        end
      endcase
    end
    @(negedge ps_clk);
    cmd.valid    = 1'b0;
    trigger      = 1'b0;
    sample.valid = 1'b0;
    tstamp.valid = 1'b0;
  endtask

  task automatic cmd_step(input buffer_pkg::cmd_op_e op);
    step(1'b1, op, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic feed(input int n, input logic force_valid);
    int r;
    repeat (n) begin
      r = $random(seed);
      step(1'b0, buffer_pkg::CMD_ARM, 1'b0, force_valid | r[0], force_valid | r[1]);
    end
  endtask

  task automatic pulse_start();
    readout_start = 1'b1;
    @(posedge ps_clk);
    @(negedge ps_clk);
    readout_start = 1'b0;
  endtask

  task automatic check_model_depth();
    buffer_pkg::depth_t exp;
    exp.samples = s_q.size();
    exp.tstamps = t_q.size();
    compare_depth(cur_test, exp, depth);
  endtask

  // frame: tstamp header, tstamps, sample header, samples
  task automatic read_frame(output int delay);
    logic [buffer_pkg::OUT_WIDTH-1:0] exp_q[$];
    buffer_pkg::readout_word_t        exp_w;
    int                               n;
    int                               i;
    exp_q.push_back(t_q.size());
    foreach (t_q[k]) exp_q.push_back(t_q[k]);
    exp_q.push_back(s_q.size());
    foreach (s_q[k]) exp_q.push_back(s_q[k]);
    pulse_start();
    delay = 1;
    while (!readout.valid && delay < TIMEOUT) begin
      @(negedge ps_clk);
      delay++;
    end
    if (!readout.valid) begin
      report_error("no readout word arrived after readout_start");
      return;
    end
    n = exp_q.size();
    for (i = 0; i < n; i++) begin
      if (!readout.valid) begin
        report_error($sformatf("readout stream stopped early at word %0d", i));
        break;
      end
      exp_w.valid = 1'b1;
      exp_w.last  = (i == n - 1);
      exp_w.data  = exp_q[i];
      compare_word(cur_test, exp_w, readout);
      expect_last(cur_test, exp_w.last, readout.last);
      @(negedge ps_clk);
    end
    if (readout.valid) report_error("readout valid still high after the last word");
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished with %0d error(s)", cur_test, errors - test_err_start);
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    check_model_depth();
    if (capture_busy !== 1'b0) report_error("capture busy high after reset");
    if (readout.valid !== 1'b0) report_error("readout valid high after reset");
    expect_last(cur_test, 1'b0, readout.last);
    end_test();
  endtask

  task automatic software_start();
    int delay;
    begin_test("software_start");
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(10, 1'b0);
    cmd_step(buffer_pkg::CMD_STOP);
    check_model_depth();
    if (capture_busy !== 1'b0) report_error("capture busy still high after stop");
    read_frame(delay);
    end_test();
  endtask

  task automatic hardware_start();
    int delay;
    begin_test("hardware_start");
    cmd_step(buffer_pkg::CMD_ARM);
    feed(5, 1'b1);
    if (depth !== '0) report_error("entries stored before the trigger");
    step(1'b0, buffer_pkg::CMD_ARM, 1'b1, 1'b1, 1'b1);
    feed(6, 1'b0);
    cmd_step(buffer_pkg::CMD_STOP);
    check_model_depth();
    read_frame(delay);
    end_test();
  endtask

  task automatic stop_on_full();
    buffer_pkg::depth_t exp;
    int                 guard;
    int                 delay;
    int                 r;
    begin_test("stop_on_full");
    cmd_step(buffer_pkg::CMD_ARM_START);
    guard = 0;
    while (m_state == buffer_pkg::CAPTURING && guard < TIMEOUT) begin
      r = $random(seed);
      step(1'b0, buffer_pkg::CMD_ARM, 1'b0, r[0], 1'b1);
      guard++;
    end
    if (capture_busy !== 1'b0) report_error("capture did not stop on a full memory");
    exp.samples = s_q.size();
    exp.tstamps = buffer_pkg::TSTAMP_DEPTH;
    compare_depth(cur_test, exp, depth);
    read_frame(delay);
    end_test();
  endtask

  task automatic capture_reset();
    int delay;
    begin_test("capture_reset");
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(6, 1'b1);
    cmd_step(buffer_pkg::CMD_RESET);
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(5, 1'b0);
    cmd_step(buffer_pkg::CMD_STOP);
    check_model_depth();
    read_frame(delay);
    end_test();
  endtask

  task automatic readout_abort();
    int waited;
    int delay;
    begin_test("readout_abort");
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(8, 1'b1);
    cmd_step(buffer_pkg::CMD_STOP);
    pulse_start();
    waited = 0;
    while (!readout.valid && waited < TIMEOUT) begin
      @(negedge ps_clk);
      waited++;
    end
    if (!readout.valid) report_error("no readout word arrived before the abort");
    repeat (3) begin
      expect_last(cur_test, 1'b0, readout.last);
      @(negedge ps_clk);
    end
    cmd_step(buffer_pkg::CMD_RESET);
    repeat (10) begin
      if (readout.valid) report_error("readout word seen after the abort");
      @(negedge ps_clk);
    end
    check_model_depth();
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(7, 1'b0);
    cmd_step(buffer_pkg::CMD_STOP);
    read_frame(delay);
    // a start while armed must be ignored
    cmd_step(buffer_pkg::CMD_ARM);
    pulse_start();
    repeat (20) begin
      if (readout.valid) report_error("readout started while capture busy");
      @(negedge ps_clk);
    end
    cmd_step(buffer_pkg::CMD_STOP);
    end_test();
  endtask

  task automatic readout_timing();
    int delay;
    begin_test("readout_timing");
    cmd_step(buffer_pkg::CMD_ARM_START);
    feed(4, 1'b1);
    cmd_step(buffer_pkg::CMD_STOP);
    read_frame(delay);
    checks++;
    if (delay != 2) begin
      $display("FAIL %s: first word delay expected %0d actual %0d", cur_test, 2, delay);
      errors++;
    end
    cmd_step(buffer_pkg::CMD_RESET);
    // a trigger while idle starts nothing
    step(1'b0, buffer_pkg::CMD_ARM, 1'b1, 1'b1, 1'b1);
    // empty memories give two headers only
    read_frame(delay);
    end_test();
  endtask

  initial begin
    ps_clk        = 1'b0;
    arst_n        = 1'b0;
    sample        = '0;
    tstamp        = '0;
    trigger       = 1'b0;
    cmd           = '0;
    readout_start = 1'b0;
    m_state       = buffer_pkg::IDLE;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    repeat (8) @(posedge ps_clk);
    @(negedge ps_clk);
    arst_n = 1'b1;
    @(negedge ps_clk);
    reset_state();
    software_start();
    hardware_start();
    stop_on_full();
    capture_reset();
    readout_abort();
    readout_timing();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/rx_pkg.sv
verilog/buffer_pkg.sv
verilog/capture_control.sv
verilog/tagged_sample_store.sv
verilog/readout_sequencer.sv
verilog/timetagging_sample_buffer.sv
bench/sample_buffer_checker.sv
bench/tb_timetagging_sample_buffer.sv

/* verilog/buffer_pkg.sv */
package buffer_pkg;

  // memory depths
  localparam int SAMPLE_DEPTH = 32;
  localparam int TSTAMP_DEPTH = 16;

  // address and count widths, counts reach the full depth
  localparam int SAMPLE_ADDR_WIDTH = $clog2(SAMPLE_DEPTH);
  localparam int TSTAMP_ADDR_WIDTH = $clog2(TSTAMP_DEPTH);
  localparam int SAMPLE_CNT_WIDTH  = SAMPLE_ADDR_WIDTH + 1;
  localparam int TSTAMP_CNT_WIDTH  = TSTAMP_ADDR_WIDTH + 1;

  // readout word
  localparam int OUT_WIDTH = 32;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURING,
    DONE
  } capture_state_e;

  typedef enum logic [1:0] {
    CMD_ARM,
    CMD_ARM_START,
    CMD_STOP,
    CMD_RESET
  } cmd_op_e;

  typedef struct packed {
    logic     valid;
    cmd_op_e  op;
  } capture_cmd_t;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_TSTAMP_HDR,
    RD_TSTAMP,
    RD_SAMPLE_HDR,
    RD_SAMPLE
  } readout_state_e;

  typedef struct packed {
    logic                  valid;
    logic                  last;
    logic [OUT_WIDTH-1:0]  data;
  } readout_word_t;

  typedef struct packed {
    logic [SAMPLE_CNT_WIDTH-1:0]  samples;
    logic [TSTAMP_CNT_WIDTH-1:0]  tstamps;
  } depth_t;

endpackage

/* verilog/capture_control.sv */
module capture_control (
  input  logic                      ps_clk,
  input  logic                      arst_n_i,
  input  buffer_pkg::capture_cmd_t  cmd_i,
  input  logic                      trigger_i,
  input  logic                      full_i,
  output logic                      write_en_o,
  output logic                      clear_o,
  output logic                      capture_busy_o
);

  buffer_pkg::capture_state_e state;
  buffer_pkg::capture_state_e state_next;

  logic idle_or_done;
  logic arm_cmd;
  logic fresh_arm;
  logic stop_cmd;
  logic reset_cmd;

  // an arm only counts when no capture is in progress
  assign idle_or_done = (state == buffer_pkg::IDLE) || (state == buffer_pkg::DONE);
  assign arm_cmd      = cmd_i.valid && ((cmd_i.op == buffer_pkg::CMD_ARM) ||
                                        (cmd_i.op == buffer_pkg::CMD_ARM_START));
  assign fresh_arm    = arm_cmd && idle_or_done;
  assign stop_cmd     = cmd_i.valid && (cmd_i.op == buffer_pkg::CMD_STOP);
  assign reset_cmd    = cmd_i.valid && (cmd_i.op == buffer_pkg::CMD_RESET);

  always_comb begin
    state_next = state;
    case (state)
      buffer_pkg::IDLE, buffer_pkg::DONE: begin
        if (fresh_arm) begin
          if (cmd_i.op == buffer_pkg::CMD_ARM_START) begin
            state_next = buffer_pkg::CAPTURING;
          end else begin
            state_next = buffer_pkg::ARMED;
          end
        end
      end
      buffer_pkg::ARMED: begin
        // waiting on the hardware trigger
        if (stop_cmd) begin
          state_next = buffer_pkg::DONE;
        end else if (trigger_i) begin
          state_next = buffer_pkg::CAPTURING;
        end
      end
      buffer_pkg::CAPTURING: begin
        if (stop_cmd || full_i) begin
          state_next = buffer_pkg::DONE;
        end
      end
      default: begin
        state_next = buffer_pkg::IDLE;
      end
    endcase
    // reset command overrides everything
    if (reset_cmd) begin
      state_next = buffer_pkg::IDLE;
    end
  end

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= buffer_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // clear lands on the same edge that enters ARMED or CAPTURING
  assign clear_o        = reset_cmd || fresh_arm;
  assign write_en_o     = (state == buffer_pkg::CAPTURING);
  assign capture_busy_o = (state == buffer_pkg::ARMED) || (state == buffer_pkg::CAPTURING);

endmodule

/* verilog/readout_sequencer.sv */
module readout_sequencer (
  input  logic                                      ps_clk,
  input  logic                                      arst_n_i,
  input  logic                                      start_i,
  input  logic                                      abort_i,
  input  logic                                      capture_busy_i,
  input  buffer_pkg::depth_t                        depth_i,
  output logic [buffer_pkg::SAMPLE_ADDR_WIDTH-1:0]  rd_addr_o,
  output logic                                      rd_tstamp_o,
  input  logic [buffer_pkg::OUT_WIDTH-1:0]          rd_data_i,
  output buffer_pkg::readout_word_t                 readout_o
);

  buffer_pkg::readout_state_e state;
  buffer_pkg::readout_state_e state_next;

  logic [buffer_pkg::SAMPLE_ADDR_WIDTH-1:0] rd_idx;
  logic [buffer_pkg::SAMPLE_ADDR_WIDTH-1:0] idx_next;

  // counts frozen for the whole frame
  logic [buffer_pkg::SAMPLE_CNT_WIDTH-1:0] sample_cnt_q;
  logic [buffer_pkg::TSTAMP_CNT_WIDTH-1:0] tstamp_cnt_q;

  logic start_ok;
  logic tstamp_at_end;
  logic sample_at_end;

  // word being issued this cycle
  logic                            emit;
  logic                            emit_last;
  logic                            emit_hdr;
  logic [buffer_pkg::OUT_WIDTH-1:0] hdr_value;

  // pipeline stage lined up with the memory read
  logic                            valid_q;
  logic                            last_q;
  logic                            hdr_q;
  logic [buffer_pkg::OUT_WIDTH-1:0] hdr_data_q;

  assign start_ok = start_i && !capture_busy_i;

  assign tstamp_at_end = ({1'b0, rd_idx[buffer_pkg::TSTAMP_ADDR_WIDTH-1:0]} ==
                          tstamp_cnt_q - 1'b1);
  assign sample_at_end = ({1'b0, rd_idx} == sample_cnt_q - 1'b1);

  always_comb begin
    state_next = state;
    idx_next   = rd_idx;
    emit       = 1'b0;
    emit_last  = 1'b0;
    emit_hdr   = 1'b0;
    hdr_value  = '0;
    case (state)
      buffer_pkg::RD_IDLE: begin
        if (start_ok) begin
          state_next = buffer_pkg::RD_TSTAMP_HDR;
        end
      end
      buffer_pkg::RD_TSTAMP_HDR: begin
        emit      = 1'b1;
        emit_hdr  = 1'b1;
        hdr_value = buffer_pkg::OUT_WIDTH'(tstamp_cnt_q);
        idx_next  = '0;
        // empty memory gives the header alone
        if (tstamp_cnt_q == '0) begin
          state_next = buffer_pkg::RD_SAMPLE_HDR;
        end else begin
          state_next = buffer_pkg::RD_TSTAMP;
        end
      end
      buffer_pkg::RD_TSTAMP: begin
        emit = 1'b1;
        if (tstamp_at_end) begin
          idx_next   = '0;
          state_next = buffer_pkg::RD_SAMPLE_HDR;
        end else begin
          idx_next = rd_idx + 1'b1;
        end
      end
      buffer_pkg::RD_SAMPLE_HDR: begin
        emit      = 1'b1;
        emit_hdr  = 1'b1;
        hdr_value = buffer_pkg::OUT_WIDTH'(sample_cnt_q);
        idx_next  = '0;
        if (sample_cnt_q == '0) begin
          emit_last  = 1'b1;
          state_next = buffer_pkg::RD_IDLE;
        end else begin
          state_next = buffer_pkg::RD_SAMPLE;
        end
      end
      buffer_pkg::RD_SAMPLE: begin
        emit = 1'b1;
        if (sample_at_end) begin
          emit_last  = 1'b1;
          idx_next   = '0;
          state_next = buffer_pkg::RD_IDLE;
        end else begin
          idx_next = rd_idx + 1'b1;
        end
      end
      default: begin
        state_next = buffer_pkg::RD_IDLE;
      end
    endcase
    // abort drops the frame, no last
    if (abort_i) begin
      state_next = buffer_pkg::RD_IDLE;
      idx_next   = '0;
      emit       = 1'b0;
      emit_last  = 1'b0;
    end
  end

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state        <= buffer_pkg::RD_IDLE;
      rd_idx       <= '0;
      sample_cnt_q <= '0;
      tstamp_cnt_q <= '0;
      valid_q      <= 1'b0;
      last_q       <= 1'b0;
      hdr_q        <= 1'b0;
    end else begin
      state   <= state_next;
      rd_idx  <= idx_next;
      valid_q <= emit;
      last_q  <= emit_last;
      hdr_q   <= emit_hdr;
      if ((state == buffer_pkg::RD_IDLE) && start_ok) begin
        sample_cnt_q <= depth_i.samples;
        tstamp_cnt_q <= depth_i.tstamps;
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (emit_hdr) begin
      hdr_data_q <= hdr_value;
    end
  end

  assign rd_addr_o   = rd_idx;
  assign rd_tstamp_o = (state == buffer_pkg::RD_TSTAMP);

  // header words bypass the memory data
  assign readout_o.valid = valid_q;
  assign readout_o.last  = last_q;
  assign readout_o.data  = hdr_q ? hdr_data_q : rd_data_i;

endmodule

/* verilog/rx_pkg.sv */
package rx_pkg;

  // receiver front end
  localparam int CHANNELS     = 2;
  localparam int DATA_WIDTH   = 16;
  localparam int TSTAMP_WIDTH = 32;

  // both channel lanes side by side
  localparam int SAMPLE_WIDTH = CHANNELS * DATA_WIDTH;

  // one sample pair per strobe, lane 0 in the low bits
  typedef struct packed {
    logic                                 valid;
    logic [CHANNELS-1:0][DATA_WIDTH-1:0]  lanes;
  } sample_in_t;

  // one timestamp per strobe
  typedef struct packed {
    logic                     valid;
    logic [TSTAMP_WIDTH-1:0]  value;
  } tstamp_in_t;

endpackage

/* verilog/tagged_sample_store.sv */
module tagged_sample_store (
  input  logic                                      ps_clk,
  input  logic                                      arst_n_i,
  input  rx_pkg::sample_in_t                        sample_i,
  input  rx_pkg::tstamp_in_t                        tstamp_i,
  input  logic                                      write_en_i,
  input  logic                                      clear_i,
  input  logic [buffer_pkg::SAMPLE_ADDR_WIDTH-1:0]  rd_addr_i,
  input  logic                                      rd_tstamp_i,
  output logic [buffer_pkg::OUT_WIDTH-1:0]          rd_data_o,
  output buffer_pkg::depth_t                        depth_o,
  output logic                                      full_o
);

  // sample pairs and timestamps, each in its own memory
  logic [rx_pkg::SAMPLE_WIDTH-1:0] sample_mem [buffer_pkg::SAMPLE_DEPTH];
  logic [rx_pkg::TSTAMP_WIDTH-1:0] tstamp_mem [buffer_pkg::TSTAMP_DEPTH];

  // write pointers double as entry counts
  logic [buffer_pkg::SAMPLE_CNT_WIDTH-1:0] sample_ptr;
  logic [buffer_pkg::TSTAMP_CNT_WIDTH-1:0] tstamp_ptr;

  logic sample_full;
  logic tstamp_full;
  logic write_ok;
  logic sample_we;
  logic tstamp_we;

  assign sample_full = (sample_ptr == buffer_pkg::SAMPLE_DEPTH);
  assign tstamp_full = (tstamp_ptr == buffer_pkg::TSTAMP_DEPTH);
  assign full_o      = sample_full || tstamp_full;

  // once either side is full nothing else goes in
  assign write_ok  = write_en_i && !full_o && !clear_i;
  assign sample_we = write_ok && sample_i.valid;
  assign tstamp_we = write_ok && tstamp_i.valid;

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_ptr <= '0;
      tstamp_ptr <= '0;
    end else if (clear_i) begin
      sample_ptr <= '0;
      tstamp_ptr <= '0;
    end else begin
      if (sample_we) begin
        sample_ptr <= sample_ptr + 1'b1;
      end
      if (tstamp_we) begin
        tstamp_ptr <= tstamp_ptr + 1'b1;
      end
    end
  end

  // memory write ports
  always_ff @(posedge ps_clk) begin
    if (sample_we) begin
      sample_mem[sample_ptr[buffer_pkg::SAMPLE_ADDR_WIDTH-1:0]] <= sample_i.lanes;
    end
    if (tstamp_we) begin
      tstamp_mem[tstamp_ptr[buffer_pkg::TSTAMP_ADDR_WIDTH-1:0]] <= tstamp_i.value;
    end
  end

  // shared read port, one cycle latency
  always_ff @(posedge ps_clk) begin
    if (rd_tstamp_i) begin
      rd_data_o <= tstamp_mem[rd_addr_i[buffer_pkg::TSTAMP_ADDR_WIDTH-1:0]];
    end else begin
      rd_data_o <= sample_mem[rd_addr_i];
    end
  end

  // counts show up the cycle after the write
  assign depth_o.samples = sample_ptr;
  assign depth_o.tstamps = tstamp_ptr;

endmodule

/* verilog/timetagging_sample_buffer.sv */
module timetagging_sample_buffer (
  input  logic                       ps_clk,
  input  logic                       arst_n_i,
  input  rx_pkg::sample_in_t         sample_i,
  input  rx_pkg::tstamp_in_t         tstamp_i,
  input  logic                       trigger_i,
  input  buffer_pkg::capture_cmd_t   cmd_i,
  input  logic                       readout_start_i,
  output buffer_pkg::readout_word_t  readout_o,
  output buffer_pkg::depth_t         depth_o,
  output logic                       capture_busy_o
);

  logic                                     write_en;
  logic                                     clear;
  logic                                     full;
  logic [buffer_pkg::SAMPLE_ADDR_WIDTH-1:0] rd_addr;
  logic                                     rd_tstamp;
  logic [buffer_pkg::OUT_WIDTH-1:0]         rd_data;

  capture_control u_capture_control (
    .ps_clk         (ps_clk),
    .arst_n_i       (arst_n_i),
    .cmd_i          (cmd_i),
    .trigger_i      (trigger_i),
    .full_i         (full),
    .write_en_o     (write_en),
    .clear_o        (clear),
    .capture_busy_o (capture_busy_o)
  );

  tagged_sample_store u_store (
    .ps_clk      (ps_clk),
    .arst_n_i    (arst_n_i),
    .sample_i    (sample_i),
    .tstamp_i    (tstamp_i),
    .write_en_i  (write_en),
    .clear_i     (clear),
    .rd_addr_i   (rd_addr),
    .rd_tstamp_i (rd_tstamp),
    .rd_data_o   (rd_data),
    .depth_o     (depth_o),
    .full_o      (full)
  );

  // clear also ends any readout in flight
  readout_sequencer u_readout (
    .ps_clk         (ps_clk),
    .arst_n_i       (arst_n_i),
    .start_i        (readout_start_i),
    .abort_i        (clear),
    .capture_busy_i (capture_busy_o),
    .depth_i        (depth_o),
    .rd_addr_o      (rd_addr),
    .rd_tstamp_o    (rd_tstamp),
    .rd_data_i      (rd_data),
    .readout_o      (readout_o)
  );

endmodule
